// ==== sim.f ====
hw/sdramPkg.sv
hw/burstFifo.sv
hw/burstArbiter.sv
hw/burstSequencer.sv
hw/sdramController.sv
verification/sdramModel.sv
verification/sdramController_assertions.sv
verification/sdramControllerTb.sv

// ==== Makefile ====
TOP = sdramControllerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/sdramControllerTb.sv ====
// Testbench for the SDRAM burst controller covering ring fill, ordered readback, wrap and flush
`timescale 1ns/10ps

module sdramControllerTb;
    import sdramPkg::*;

    localparam int ClkPeriod = 20;
    localparam int RingWords = 32;              // Four bursts per ring
    localparam int WatchdogCycles = 4 + InitDoneAt + 40 * BurstCycles + 200;

    logic               CLK;
    logic               RESET_N;
    logic               wrStrobe;
    word_t              wrData;
    logic               wrFull;
    logic               rdStrobe;
    word_t              rdData;
    logic               rdEmpty;
    logic               rdEnable;
    logic [RowBits-1:0]  SA;
    logic [BankBits-1:0] BA;
    logic               CS_N;
    logic               CKE;
    logic               RAS_N;
    logic               CAS_N;
    logic               WE_N;
    wire word_t         DQ;
    logic               DQM;

    int    seed = 67;
    word_t shadow [RingWords];                  // Expected ring contents
    word_t expectQ [$];                         // Scoreboard for readback
    int    writeIndex = 0;
    int    writeCount = 0;                      // WRITE commands seen
    int    readCount = 0;
    logic [RowBits-1:0] activeRow;

    sdramController u_dut (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .wrStrobe    (wrStrobe),
        .wrData      (wrData),
        .wrFull      (wrFull),
        .rdStrobe    (rdStrobe),
        .rdData      (rdData),
        .rdEmpty     (rdEmpty),
        .rdEnable    (rdEnable),
        .wrStartAddr (addr_t'(0)),
        .wrMaxAddr   (addr_t'(RingWords)),
        .rdStartAddr (addr_t'(0)),
        .rdMaxAddr   (addr_t'(RingWords)),
        .SA          (SA),
        .BA          (BA),
        .CS_N        (CS_N),
        .CKE         (CKE),
        .RAS_N       (RAS_N),
        .CAS_N       (CAS_N),
        .WE_N        (WE_N),
        .DQ          (DQ),
        .DQM         (DQM)
    );

    sdramModel u_sdramModel (
        .CLK   (CLK),
        .CKE   (CKE),
        .CS_N  (CS_N),
        .RAS_N (RAS_N),
        .CAS_N (CAS_N),
        .WE_N  (WE_N),
        .BA    (BA),
        .SA    (SA),
        .DQ    (DQ)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(ClkPeriod / 2) CLK = ~CLK;
    end

    task automatic stopOnFailure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] expected);
        $display("Error: %s = 0x%h, expected 0x%h", name, got, expected);
        stopOnFailure();
    endtask

    // Push words on falling edges and never into a full FIFO
    task automatic pushWords(int n);
        for (int i = 0; i < n; i++)
        begin
            @(negedge CLK);
            wrStrobe = 1'b0;
            while (wrFull)
            begin
                @(negedge CLK);
            end
            wrData   = word_t'($random(seed));
            wrStrobe = 1'b1;
            shadow[writeIndex % RingWords] = wrData;   // Write ring is linear
            writeIndex++;
        end
        @(negedge CLK);
        wrStrobe = 1'b0;
    endtask

    // Pop n words and compare each with the scoreboard one cycle later
    task automatic popAndCompare(int n);
        int    issued;
        int    got;
        bit    pending;
        word_t expected;
        issued  = 0;
        got     = 0;
        pending = 0;
        while (got < n)
        begin
            @(negedge CLK);
            if (pending)
            begin
                expected = expectQ.pop_front();
                if (rdData !== expected)
                begin
                    reportMismatch("rdData", rdData, expected);
                end
                got++;
            end
            rdStrobe = (issued < n) && !rdEmpty;
            pending  = rdStrobe;
            if (rdStrobe)
            begin
                issued++;
            end
        end
    endtask

    task automatic waitForWrites(int n);
        while (writeCount < n)
        begin
            @(negedge CLK);
        end
    endtask

    // ==========================================================================
    // Command monitor for burst counts and the wrap check
    // ==========================================================================
    always @(posedge CLK)
    begin
        if (RESET_N && !CS_N)
        begin
            case ({RAS_N, CAS_N, WE_N})
                CmdActive: activeRow = SA;
                CmdRead:   readCount++;
                CmdWrite:
                begin
                    writeCount++;
                    if (writeCount == RingWords / BurstLen + 1)
                    begin
                        // Fifth write burst is back at the ring start
                        if (SA[ColBits-1:0] != '0)
                        begin
                            reportMismatch("writeColumn", SA[ColBits-1:0], 0);
                        end
                        if (activeRow != '0)
                        begin
                            reportMismatch("activeRow", activeRow, 0);
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always @(posedge CLK)
    begin
        if (u_dut.u_assertions.errorCount != 0)
        begin
            $display("A protocol assertion failed");
            stopOnFailure();
        end
    end

    // Watchdog
    initial
    begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog timeout, the test did not finish in time");
        stopOnFailure();
    end

    // ==========================================================================
    // Main sequence
    // ==========================================================================
    initial
    begin
        int readPos;
        int n;
        RESET_N  = 1'b0;
        wrStrobe = 1'b0;
        wrData   = '0;
        rdStrobe = 1'b0;
        rdEnable = 1'b0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RESET_N = 1'b1;

        // Fill the whole ring with the read side off
        pushWords(RingWords);
        // Init is still running so no word has left the FIFO yet
        if (wrFull !== 1'b1)
        begin
            reportMismatch("wrFull", wrFull, 1);
        end
        waitForWrites(RingWords / BurstLen);
        for (int i = 0; i < RingWords; i++)
        begin
            expectQ.push_back(shadow[i]);
        end
        @(negedge CLK);
        rdEnable = 1'b1;
        popAndCompare(RingWords);

        // Flush while rereads wait in the FIFO
        while (rdEmpty)
        begin
            @(negedge CLK);
        end
        rdEnable = 1'b0;

        // Wrap the write ring and read on from where the read ring stands
        pushWords(BurstLen);
        waitForWrites(RingWords / BurstLen + 1);
        readPos = (readCount % (RingWords / BurstLen)) * BurstLen;
        n = ((RingWords - readPos) % RingWords) + BurstLen;
        for (int k = 0; k < n; k++)
        begin
            expectQ.push_back(shadow[(readPos + k) % RingWords]);
        end
        @(negedge CLK);
        rdEnable = 1'b1;
        popAndCompare(n);

        repeat (4) @(negedge CLK);
        if (u_dut.u_assertions.errorCount == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            stopOnFailure();
        end
    end

endmodule

// ==== verification/sdramController_assertions.sv ====
// Bound SDRAM pin protocol checks, init order, burst timing, data bus use and read flush
`timescale 1ns/10ps

module sdramController_assertions
    import sdramPkg::*;
(
    input logic                CLK,
    input logic                RESET_N,
    input logic [RowBits-1:0]  SA,
    input logic [BankBits-1:0] BA,
    input logic                CS_N,
    input logic                RAS_N,
    input logic                CAS_N,
    input logic                WE_N,
    input logic                DQM,
    input logic                dqOe,            // Sequencer DQ drive
    input logic                rdEnable,
    input logic                rdEmpty
);

    cmd_t        cmd;
    logic [2:0]  initCount;                     // Init commands seen so far
    int unsigned sinceActive;                   // Cycles since last ACTIVE
    logic [15:0] wrHist;                        // Bit k: WRITE k+1 cycles ago
    logic [15:0] rdHist;
    logic        writeWin;
    logic        readWin;
    int unsigned errorCount = 0;                // Seen by the testbench

    assign cmd      = {RAS_N, CAS_N, WE_N};
    assign writeWin = (cmd == CmdWrite) || (|wrHist[BurstLen-2:0]);
    assign readWin  = |rdHist[CasLatency+BurstLen-2:CasLatency-1];

    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            initCount   <= '0;
            sinceActive <= BurstCycles;
            wrHist      <= '0;
            rdHist      <= '0;
        end
        else
        begin
            if (cmd == CmdPrecharge || cmd == CmdRefresh || cmd == CmdLoadMode)
            begin
                initCount <= initCount + 1'b1;
            end
            if (cmd == CmdActive)
            begin
                sinceActive <= 1;
            end
            else if (sinceActive < BurstCycles)
            begin
                sinceActive <= sinceActive + 1;
            end
            wrHist <= {wrHist[14:0], cmd == CmdWrite};
            rdHist <= {rdHist[14:0], cmd == CmdRead};
        end
    end

    // ==========================================================================
    // Initialisation order
    // ==========================================================================
    assert property (@(posedge CLK) disable iff (!RESET_N)
        cmd == CmdPrecharge |-> initCount == 0 && SA[ApBit])
        else begin $error("Precharge out of order or not all banks"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        cmd == CmdRefresh |-> initCount == 1 || initCount == 2)
        else begin $error("Refresh out of order"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        cmd == CmdLoadMode |-> initCount == 3 && SA == ModeValue && BA == '0)
        else begin $error("Load mode out of order or wrong value"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        (cmd == CmdActive || cmd == CmdRead || cmd == CmdWrite) |-> initCount == 4)
        else begin $error("Burst command before init finished"); errorCount++; end

    // Burst command timing
    assert property (@(posedge CLK) disable iff (!RESET_N)
        $past(cmd, TRcd) == CmdActive |-> (cmd == CmdRead || cmd == CmdWrite) && SA[ApBit])
        else begin $error("No auto-precharge column command after ACTIVE"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        (cmd == CmdRead || cmd == CmdWrite) |-> $past(cmd, TRcd) == CmdActive)
        else begin $error("Column command without ACTIVE"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        cmd == CmdActive |-> sinceActive >= BurstCycles)
        else begin $error("ACTIVE commands too close"); errorCount++; end

    // ==========================================================================
    // Data bus and read side
    // ==========================================================================
    assert property (@(posedge CLK) disable iff (!RESET_N)
        !CS_N |-> DQM == !(writeWin || readWin))
        else begin $error("DQM outside its data window"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        dqOe == writeWin)
        else begin $error("DQ driven outside write data"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        $fell(rdEnable) |=> rdEmpty)
        else begin $error("Read FIFO not flushed"); errorCount++; end
    assert property (@(posedge CLK) disable iff (!RESET_N)
        cmd == CmdRead |-> $past(rdEnable, TRcd + 2))
        else begin $error("READ started with read side disabled"); errorCount++; end

endmodule

bind sdramController sdramController_assertions u_assertions (
    .CLK      (CLK),
    .RESET_N  (RESET_N),
    .SA       (SA),
    .BA       (BA),
    .CS_N     (CS_N),
    .RAS_N    (RAS_N),
    .CAS_N    (CAS_N),
    .WE_N     (WE_N),
    .DQM      (DQM),
    .dqOe     (u_burstSequencer.dqOe),
    .rdEnable (rdEnable),
    .rdEmpty  (rdEmpty)
);

// ==== verification/sdramModel.sv ====
// Behavioural SDRAM, ACTIVE opens a row, READ and WRITE move one burst
`timescale 1ns/10ps

module sdramModel
    import sdramPkg::*;
(
    input  logic                CLK,
    input  logic                CKE,
    input  logic                CS_N,
    input  logic                RAS_N,
    input  logic                CAS_N,
    input  logic                WE_N,
    input  logic [BankBits-1:0] BA,
    input  logic [RowBits-1:0]  SA,
    inout  wire word_t          DQ
);

    word_t              mem [int];                // Sparse storage by linear address
    logic [RowBits-1:0] openRow [4];              // One open row per bank
    word_t              dqOut;
    logic               dqOe;
    cmd_t               cmd;

    assign cmd = {RAS_N, CAS_N, WE_N};
    assign DQ  = dqOe ? dqOut : {DataBits{1'bz}};

    // ==========================================================================
    // Command decode and burst data
    // ==========================================================================
    always @(posedge CLK)
    begin
        int           idx;
        static int    rdStep   = 0;
        static int    wrIdx    = BurstLen;        // Idle when at BurstLen
        static bit    rdActive = 0;
        static addr_t rdBase   = '0;
        static addr_t wrBase   = '0;
        dqOe <= 1'b0;
        // Bursts already running
        if (rdActive)
        begin
            rdStep++;
            idx = rdStep - (CasLatency - 1);      // Word index on DQ next cycle
            if (idx >= 0 && idx < BurstLen)
            begin
                dqOut <= mem.exists(int'(rdBase) + idx) ? mem[int'(rdBase) + idx] : '0;
                dqOe  <= 1'b1;
            end
            if (idx >= BurstLen - 1)
            begin
                rdActive = 0;
            end
        end
        if (wrIdx < BurstLen)
        begin
            mem[int'(wrBase) + wrIdx] = DQ;       // Remaining write words
            wrIdx++;
        end
        // New command
        if (CKE && !CS_N)
        begin
            case (cmd)
                CmdActive: openRow[BA] = SA;
                CmdRead:
                begin
                    rdBase   = {BA, openRow[BA], SA[ColBits-1:0]};
                    rdStep   = 0;
                    rdActive = 1;
                end
                CmdWrite:
                begin
                    wrBase      = {BA, openRow[BA], SA[ColBits-1:0]};
                    mem[wrBase] = DQ;             // First word comes with WRITE
                    wrIdx       = 1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/sdramController.sv ====
// SDRAM burst controller top, write and read FIFOs around the arbiter and sequencer
`timescale 1ns/10ps

module sdramController
    import sdramPkg::*;
(
    input  logic                CLK,
    input  logic                RESET_N,
    // Host write port
    input  logic                wrStrobe,
    input  word_t               wrData,
    output logic                wrFull,
    // Host read port
    input  logic                rdStrobe,
    output word_t               rdData,
    output logic                rdEmpty,
    input  logic                rdEnable,     // Low holds the read side empty
    // Ring limits, steady after reset
    input  addr_t               wrStartAddr,
    input  addr_t               wrMaxAddr,
    input  addr_t               rdStartAddr,
    input  addr_t               rdMaxAddr,
    // SDRAM pins
    output logic [RowBits-1:0]  SA,
    output logic [BankBits-1:0] BA,
    output logic                CS_N,
    output logic                CKE,
    output logic                RAS_N,
    output logic                CAS_N,
    output logic                WE_N,
    inout  wire word_t          DQ,
    output logic                DQM
);

    count_t wrCount;
    count_t rdCount;
    word_t  wrWord;                           // Write FIFO to DQ
    word_t  rdWord;                           // Captured DQ to read FIFO
    logic   wrPop;
    logic   rdPush;
    logic   burstStart;
    logic   burstWrite;
    addr_t  burstAddr;
    logic   ready;
    logic   burstDone;

    // ==========================================================================
    // Host side buffers
    // ==========================================================================
    burstFifo u_wrFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .flush    (1'b0),                     // Never cleared
        .push     (wrStrobe),
        .pushData (wrData),
        .pop      (wrPop),
        .popData  (wrWord),
        .count    (wrCount),
        .full     (wrFull),
        .empty    ()
    );

    burstFifo u_rdFifo (
        .CLK      (CLK),
        .RESET_N  (RESET_N),
        .flush    (!rdEnable),
        .push     (rdPush),
        .pushData (rdWord),
        .pop      (rdStrobe),
        .popData  (rdData),
        .count    (rdCount),
        .full     (),
        .empty    (rdEmpty)
    );

    // ==========================================================================
    // Burst control
    // ==========================================================================
    burstArbiter u_burstArbiter (
        .CLK         (CLK),
        .RESET_N     (RESET_N),
        .wrStartAddr (wrStartAddr),
        .wrMaxAddr   (wrMaxAddr),
        .rdStartAddr (rdStartAddr),
        .rdMaxAddr   (rdMaxAddr),
        .rdEnable    (rdEnable),
        .wrCount     (wrCount),
        .rdCount     (rdCount),
        .ready       (ready),
        .burstDone   (burstDone),
        .burstStart  (burstStart),
        .burstWrite  (burstWrite),
        .burstAddr   (burstAddr)
    );

    burstSequencer u_burstSequencer (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .burstStart (burstStart),
        .burstWrite (burstWrite),
        .burstAddr  (burstAddr),
        .wrWord     (wrWord),
        .ready      (ready),
        .burstDone  (burstDone),
        .wrPop      (wrPop),
        .rdPush     (rdPush),
        .rdWord     (rdWord),
        .SA         (SA),
        .BA         (BA),
        .CS_N       (CS_N),
        .CKE        (CKE),
        .RAS_N      (RAS_N),
        .CAS_N      (CAS_N),
        .WE_N       (WE_N),
        .DQ         (DQ),
        .DQM        (DQM)
    );

endmodule

// ==== hw/burstSequencer.sv ====
// SDRAM command sequencer, power-up init then one ACTIVE plus auto-precharge burst per request
`timescale 1ns/10ps

module burstSequencer
    import sdramPkg::*;
(
    input  logic                CLK,
    input  logic                RESET_N,
    input  logic                burstStart,
    input  logic                burstWrite,
    input  addr_t               burstAddr,
    input  word_t               wrWord,       // Write FIFO output
    output logic                ready,
    output logic                burstDone,
    output logic                wrPop,
    output logic                rdPush,
    output word_t               rdWord,
    output logic [RowBits-1:0]  SA,
    output logic [BankBits-1:0] BA,
    output logic                CS_N,
    output logic                CKE,
    output logic                RAS_N,
    output logic                CAS_N,
    output logic                WE_N,
    inout  wire word_t          DQ,
    output logic                DQM
);

    step_t               step;                // Current cycle of init or burst
    step_t               nextStep;
    logic                initDone;
    logic                isWrite;             // Kind of current burst
    logic                dqOe;                // DQ output enable
    cmd_t                cmd;
    logic [ColBits-1:0]  colReg;
    logic [RowBits-1:0]  colAddr;             // Column plus auto-precharge
    logic                popWin;
    logic                wrWin;
    logic                rdWin;
    logic                capWin;

    assign nextStep = step + 1'b1;

    // Windows are judged on the cycle the pins will show next
    assign popWin = (nextStep >= step_t'(TRcd - 1)) &&
                    (nextStep <= step_t'(TRcd + BurstLen - 2));    // One ahead of data
    assign wrWin  = (nextStep >= step_t'(TRcd)) &&
                    (nextStep <= step_t'(TRcd + BurstLen - 1));
    assign rdWin  = (nextStep >= step_t'(TRcd + CasLatency)) &&
                    (nextStep <= step_t'(TRcd + CasLatency + BurstLen - 1));
    // Read data on DQ right now
    assign capWin = (step >= step_t'(TRcd + CasLatency)) &&
                    (step <= step_t'(TRcd + CasLatency + BurstLen - 1));

    always_comb
    begin
        colAddr                = '0;
        colAddr[ColBits-1:0]   = colReg;
        colAddr[ApBit]         = 1'b1;       // READ/WRITE with auto-precharge
    end

    assign {RAS_N, CAS_N, WE_N} = cmd;
    assign DQ = dqOe ? wrWord : {DataBits{1'bz}};

    // ==========================================================================
    // Init and burst sequencing, all pins registered
    // ==========================================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            step      <= '0;
            initDone  <= 1'b0;
            ready     <= 1'b0;
            isWrite   <= 1'b0;
            burstDone <= 1'b0;
            wrPop     <= 1'b0;
            rdPush    <= 1'b0;
            cmd       <= CmdNop;
            SA        <= '0;
            BA        <= '0;
            CS_N      <= 1'b1;               // Deselected
            CKE       <= 1'b0;
            dqOe      <= 1'b0;
            DQM       <= 1'b1;
            colReg    <= '0;
        end
        else
        begin
            CS_N      <= 1'b0;
            CKE       <= 1'b1;
            cmd       <= CmdNop;             // NOP unless set below
            burstDone <= 1'b0;
            wrPop     <= 1'b0;
            rdPush    <= 1'b0;
            dqOe      <= 1'b0;
            DQM       <= 1'b1;
            if (!initDone)
            begin
                // Power-up: wait, precharge all, 2x refresh, load mode
                step <= nextStep;
                case (step)
                    step_t'(InitPrechargeAt):
                    begin
                        cmd <= CmdPrecharge;
                        SA  <= RowBits'(1) << ApBit;   // All banks
                    end
                    step_t'(InitRefresh1At): cmd <= CmdRefresh;
                    step_t'(InitRefresh2At): cmd <= CmdRefresh;
                    step_t'(InitLoadAt):
                    begin
                        cmd <= CmdLoadMode;
                        SA  <= ModeValue;
                        BA  <= '0;
                    end
                    step_t'(InitDoneAt):
                    begin
                        initDone <= 1'b1;
                        ready    <= 1'b1;
                        step     <= '0;
                    end
                    default: ;
                endcase
            end
            else if (ready)
            begin
                // Idle, take a request and open the row
                if (burstStart)
                begin
                    ready   <= 1'b0;
                    step    <= '0;
                    isWrite <= burstWrite;
                    cmd     <= CmdActive;
                    BA      <= burstAddr[AddrBits-1 -: BankBits];
                    SA      <= burstAddr[ColBits +: RowBits];
                    colReg  <= burstAddr[ColBits-1:0];
                end
            end
            else
            begin
                step <= nextStep;
                if (nextStep == step_t'(TRcd))
                begin
                    cmd <= isWrite ? CmdWrite : CmdRead;
                    SA  <= colAddr;          // BA still holds the bank
                end
                wrPop  <= isWrite && popWin;
                dqOe   <= isWrite && wrWin;
                DQM    <= !((isWrite && wrWin) || (!isWrite && rdWin));
                rdPush <= !isWrite && capWin;  // Word lands one cycle after DQ
                if (nextStep == step_t'(BurstCycles - 1))
                begin
                    burstDone <= 1'b1;
                    ready     <= 1'b1;       // Next ACTIVE may follow
                end
            end
        end
    end

    // Read data capture
    always_ff @(posedge CLK)
    begin
        if (capWin && !isWrite)
        begin
            rdWord <= DQ;
        end
    end

endmodule

// ==== hw/burstArbiter.sv ====
// Burst arbiter, keeps the write and read ring addresses and picks the next burst
`timescale 1ns/10ps

module burstArbiter
    import sdramPkg::*;
(
    input  logic   CLK,
    input  logic   RESET_N,
    input  addr_t  wrStartAddr,
    input  addr_t  wrMaxAddr,
    input  addr_t  rdStartAddr,
    input  addr_t  rdMaxAddr,
    input  logic   rdEnable,
    input  count_t wrCount,               // Words waiting in write FIFO
    input  count_t rdCount,               // Words held in read FIFO
    input  logic   ready,                 // Sequencer idle
    input  logic   burstDone,
    output logic   burstStart,
    output logic   burstWrite,            // Also the kind of the burst in flight
    output addr_t  burstAddr
);

    addr_t wrAddr;                        // Next write burst
    addr_t rdAddr;                        // Next read burst
    addr_t wrNext;
    addr_t rdNext;
    logic  armed;                         // Ring start addresses loaded
    logic  pending;                       // Burst issued, waiting for done
    logic  wantWrite;
    logic  wantRead;

    // A full burst waits on the write side
    assign wantWrite = (int'(wrCount) >= BurstLen);
    // Room for a whole burst on the read side
    assign wantRead  = rdEnable && (int'(rdCount) <= FifoDepth - BurstLen);

    assign wrNext = wrAddr + addr_t'(BurstLen);
    assign rdNext = rdAddr + addr_t'(BurstLen);

    // ==========================================================================
    // Burst selection and ring advance
    // ==========================================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            armed      <= 1'b0;
            pending    <= 1'b0;
            burstStart <= 1'b0;
            burstWrite <= 1'b0;
            burstAddr  <= '0;
            wrAddr     <= '0;
            rdAddr     <= '0;
        end
        else
        begin
            burstStart <= 1'b0;           // Single-cycle strobe
            if (!armed)
            begin
                // First cycle out of reset
                armed  <= 1'b1;
                wrAddr <= wrStartAddr;
                rdAddr <= rdStartAddr;
            end
            else if (pending)
            begin
                if (burstDone)
                begin
                    pending <= 1'b0;
                    // Advance only the ring just served
                    if (burstWrite)
                    begin
                        wrAddr <= (wrNext >= wrMaxAddr) ? wrStartAddr : wrNext;
                    end
                    else
                    begin
                        rdAddr <= (rdNext >= rdMaxAddr) ? rdStartAddr : rdNext;
                    end
                end
            end
            else if (ready && (wantWrite || wantRead))
            begin
                pending    <= 1'b1;
                burstStart <= 1'b1;
                burstWrite <= wantWrite;  // Writes win
                burstAddr  <= wantWrite ? wrAddr : rdAddr;
            end
        end
    end

endmodule

// ==== hw/burstFifo.sv ====
// Single-clock word FIFO with fill count, registered read port and synchronous flush
`timescale 1ns/10ps

module burstFifo
    import sdramPkg::*;
(
    input  logic   CLK,
    input  logic   RESET_N,
    input  logic   flush,                 // Drops all contents
    input  logic   push,
    input  word_t  pushData,
    input  logic   pop,
    output word_t  popData,               // Valid the cycle after pop
    output count_t count,
    output logic   full,
    output logic   empty
);

    word_t mem [FifoDepth];
    ptr_t  wrPtr;
    ptr_t  rdPtr;
    logic  doPush;
    logic  doPop;

    assign full   = (count == count_t'(FifoDepth));
    assign empty  = (count == '0);
    assign doPush = push && !full;        // Overflow guard
    assign doPop  = pop && !empty;

    // Storage and output word
    always_ff @(posedge CLK)
    begin
        if (doPush)
        begin
            mem[wrPtr] <= pushData;
        end
        if (doPop)
        begin
            popData <= mem[rdPtr];
        end
    end

    // ==========================================================================
    // Pointers and fill count
    // ==========================================================================
    always_ff @(posedge CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (flush)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
            begin
                wrPtr <= wrPtr + 1'b1;    // Natural wrap at FifoDepth
            end
            if (doPop)
            begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push and pop together
            endcase
        end
    end

endmodule

// ==== hw/sdramPkg.sv ====
// SDRAM burst controller package, geometry, timing, burst schedule and command codes
package sdramPkg;

    // ==========================================================================
    // Geometry
    // ==========================================================================
    localparam int DataBits = 16;                          // DQ and host word width
    localparam int BankBits = 2;
    localparam int RowBits  = 12;                          // Also the SA pin width
    localparam int ColBits  = 8;
    localparam int AddrBits = BankBits + RowBits + ColBits; // Bank, row, column
    localparam int ApBit    = 10;                          // Auto-precharge / all-banks bit

    // ==========================================================================
    // Burst and timing, all in CLK cycles
    // ==========================================================================
    localparam int BurstLen   = 8;                         // Matches mode register
    localparam int CasLatency = 2;
    localparam int TRcd       = 2;                         // ACTIVE to column command
    localparam int TRp        = 2;                         // Covers auto-precharge
    localparam int TRfc       = 7;
    localparam int TMrd       = 2;
    localparam int InitWait   = 20;                        // Short power-up wait for sim
    // ACTIVE to earliest next ACTIVE
    localparam int BurstCycles = TRcd + CasLatency + BurstLen + TRp;

    // Power-up schedule as sequencer step numbers
    localparam int InitPrechargeAt = InitWait;
    localparam int InitRefresh1At  = InitPrechargeAt + TRp;
    localparam int InitRefresh2At  = InitRefresh1At + TRfc;
    localparam int InitLoadAt      = InitRefresh2At + TRfc;
    localparam int InitDoneAt      = InitLoadAt + TMrd;
    localparam int StepBits        = 6;                    // Holds InitDoneAt

    // ==========================================================================
    // FIFO sizing
    // ==========================================================================
    localparam int FifoDepth = 32;
    localparam int PtrBits   = 5;
    localparam int CountBits = 6;                          // 0 to FifoDepth inclusive

    typedef logic [DataBits-1:0]  word_t;
    typedef logic [AddrBits-1:0]  addr_t;
    typedef logic [CountBits-1:0] count_t;
    typedef logic [PtrBits-1:0]   ptr_t;
    typedef logic [StepBits-1:0]  step_t;
    typedef logic [2:0]           cmd_t;                   // {RAS_N, CAS_N, WE_N}

    // Command codes
    localparam cmd_t CmdNop       = 3'b111;
    localparam cmd_t CmdActive    = 3'b011;
    localparam cmd_t CmdRead      = 3'b101;
    localparam cmd_t CmdWrite     = 3'b100;
    localparam cmd_t CmdPrecharge = 3'b010;
    localparam cmd_t CmdRefresh   = 3'b001;
    localparam cmd_t CmdLoadMode  = 3'b000;

    // Burst 8, sequential, CAS latency 2, burst write
    localparam logic [RowBits-1:0] ModeValue = 12'h023;

endpackage
